/* tests/vec_lsu_input.txt */
# columns: test name, opcode, lmul code, base word address (hex), expected beats
# expected beats 0 marks a start that the unit must ignore
store_m1   9 0 0100 1
store_m2   7 1 0200 2
store_m4   8 2 03f4 4
load_m1    1 0 0100 1
load_m2    2 1 0200 2
load_m4    3 2 03f4 4
load_wrap  3 2 fff8 4
store_bad  10 1 0400 0
load_bad   4 2 0500 0
lmul_rsvd  2 3 0600 1

/* vec_lsu.f */
verilog/lsu_geom_pkg.sv
verilog/lsu_instr_pkg.sv
verilog/vec_cmd_decode.sv
verilog/vec_beat_sequencer.sv
verilog/vec_store_slicer.sv
verilog/vec_load_packer.sv
verilog/vec_lsu.sv
tests/vec_lsu_checker.sv
tests/tb_vec_lsu.sv

/* tests/tb_vec_lsu.sv */
/*
  testbench for vec_lsu
  run from the project root so that tests/vec_lsu_input.txt is found
  at most 32 tests are read
  bank model covers the whole word address space with a registered read
  every accepted command gets a second start while busy, which must be dropped
*/
`timescale 1ns/1ps
`default_nettype none

module tb_vec_lsu;

    localparam int NB         = lsu_geom_pkg::NUM_BANKS;
    localparam int BW         = lsu_geom_pkg::BANK_WIDTH;
    localparam int AW         = lsu_geom_pkg::ADDR_WIDTH;
    localparam int MB         = lsu_geom_pkg::MAX_BEATS;
    localparam int RL         = lsu_geom_pkg::READ_LATENCY;
    localparam int VEC_BITS   = NB * BW * MB;
    localparam int MAX_TESTS  = 32;
    localparam int CLK_PERIOD = 4;
    localparam string TEST_FILE = "tests/vec_lsu_input.txt";

    logic                         clk;
    logic                         nrst;
    logic                         start;
    lsu_instr_pkg::lsu_op_t       op;
    lsu_instr_pkg::lmul_t         lmul;
    logic [AW-1:0]                base_addr;
    logic [VEC_BITS-1:0]          store_data;
    logic                         busy;
    logic                         done;
    logic [VEC_BITS-1:0]          load_data;
    logic [NB-1:0][AW-1:0]        bank_addr;
    logic [NB-1:0][BW-1:0]        bank_wdata;
    logic                         bank_we;
    logic [NB-1:0][BW-1:0]        bank_rdata;

    logic [BW-1:0]                mem [NB][2**AW];
    logic [NB-1:0][BW-1:0]        rd_pipe [RL];

    logic [8*16-1:0]              t_name [MAX_TESTS];
    int                           t_op [MAX_TESTS];
    int                           t_lmul [MAX_TESTS];
    int                           t_beats [MAX_TESTS];
    logic [AW-1:0]                t_base [MAX_TESTS];
    int                           n_tests;
    logic                         tests_loaded;

    logic [8*16-1:0]              cur_name;
    int                           cur_beats;
    logic [31:0]                  rng;
    int                           tb_errors;
    int                           chk_errors;
    int                           chk_checks;
    int                           total;

    vec_lsu UUT (
        .clk        (clk),
        .nrst       (nrst),
        .start      (start),
        .op         (op),
        .lmul       (lmul),
        .base_addr  (base_addr),
        .store_data (store_data),
        .busy       (busy),
        .done       (done),
        .load_data  (load_data),
        .bank_addr  (bank_addr),
        .bank_wdata (bank_wdata),
        .bank_we    (bank_we),
        .bank_rdata (bank_rdata)
    );

    vec_lsu_checker u_check (
        .clk        (clk),
        .nrst       (nrst),
        .start      (start),
        .op         (op),
        .base_addr  (base_addr),
        .store_data (store_data),
        .busy       (busy),
        .done       (done),
        .load_data  (load_data),
        .bank_addr  (bank_addr),
        .bank_wdata (bank_wdata),
        .bank_we    (bank_we),
        .test_name  (cur_name),
        .exp_beats  (cur_beats),
        .errors     (chk_errors),
        .checks     (chk_checks)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // banks read every cycle, write only on bank_we
    always @(posedge clk) begin
        for (int i = 0; i < NB; i++) begin
            if (bank_we) begin
                mem[i][bank_addr[i]] <= bank_wdata[i];
            end
            rd_pipe[0][i] <= mem[i][bank_addr[i]];
        end
        for (int s = 1; s < RL; s++) begin
            rd_pipe[s] <= rd_pipe[s-1];
        end
    end

    assign bank_rdata = rd_pipe[RL-1];

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic read_tests();
        int               fd;
        int               n;
        int               opc;
        int               lm;
        int               bc;
        logic [31:0]      ba;
        logic [8*16-1:0]  name;
        logic [8*96-1:0]  line;
        n_tests = 0;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            tb_errors++;
            $display("cannot open the test file %0s", TEST_FILE);
        end else begin
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                line = '0;
                if ($fgets(line, fd) != 0) begin
                    // comment and blank lines do not give all five fields
                    n = $sscanf(line, "%s %d %d %h %d", name, opc, lm, ba, bc);
                    if (n == 5) begin
                        t_name[n_tests]  = name;
                        t_op[n_tests]    = opc;
                        t_lmul[n_tests]  = lm;
                        t_base[n_tests]  = ba[AW-1:0];
                        t_beats[n_tests] = bc;
                        n_tests++;
                    end
                end
            end
            $fclose(fd);
        end
        if (n_tests == 0) begin
            tb_errors++;
            $display("no tests were read from %0s", TEST_FILE);
        end
    endtask

    task automatic preset_banks(input logic [AW-1:0] base);
        logic [AW-1:0] a;
        for (int w = 0; w < NB * MB; w++) begin
            a = base + AW'(w);
            mem[w % NB][a] = u_check.bank_word(a, w % NB);
        end
    endtask

    task automatic wait_for_done(input logic [8*16-1:0] name);
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!done && waited < MB + 6);
        if (!done) begin
            tb_errors++;
            $display("%0s: no done within %0d cycles", name, MB + 6);
        end
    endtask

    task automatic run_test(input int t);
        logic [VEC_BITS-1:0] vec;
        logic                kept_run;
        logic                is_load;
        kept_run = (t_beats[t] != 0);
        is_load  = (t_op[t] >= 1 && t_op[t] <= 3);
        if (is_load) begin
            preset_banks(t_base[t]);
        end
        for (int w = 0; w < NB * MB; w++) begin
            rng = xorshift32(rng);
            vec[w*BW +: BW] = rng;
        end
        @(posedge clk);
        start      <= 1'b1;
        op         <= lsu_instr_pkg::lsu_op_t'(t_op[t]);
        lmul       <= lsu_instr_pkg::lmul_t'(t_lmul[t]);
        base_addr  <= t_base[t];
        store_data <= vec;
        cur_name   <= t_name[t];
        cur_beats  <= t_beats[t];
        @(posedge clk);
        if (kept_run) begin
            // lands while accept is high
            start      <= 1'b1;
            op         <= is_load ? lsu_instr_pkg::vse32 : lsu_instr_pkg::vle8;
            base_addr  <= ~t_base[t];
            store_data <= ~vec;
            @(posedge clk);
        end
        start <= 1'b0;
        if (kept_run) begin
            wait_for_done(t_name[t]);
        end else begin
            // longest command would be done by now
            repeat (MB + 4) @(posedge clk);
        end
    endtask

    initial begin
        clk          = 1'b0;
        nrst         = 1'b0;
        start        = 1'b0;
        op           = lsu_instr_pkg::vle8;
        lmul         = lsu_instr_pkg::m1;
        base_addr    = '0;
        store_data   = '0;
        cur_name     = "reset";
        cur_beats    = 0;
        rng          = 32'he0b6;
        tb_errors    = 0;
        tests_loaded = 1'b0;
        for (int s = 0; s < RL; s++) begin
            rd_pipe[s] = '0;
        end
        read_tests();
        tests_loaded = 1'b1;
        repeat (10) @(posedge clk);
        nrst <= 1'b1;
        repeat (2) @(posedge clk);
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        repeat (3) @(negedge clk);
        total = tb_errors + chk_errors;
        $display("tests: %0d, checks: %0d, errors: %0d", n_tests, chk_checks, total);
        if (total == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // budget per test covers start, the busy start, beats, tail and gap
    initial begin
        wait (tests_loaded == 1'b1);
        #((n_tests * (MB + 10) + 10) * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles", n_tests * (MB + 10) + 10);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/vec_lsu_checker.sv */
/*
  watches the DUT ports and checks each accepted command against the
  transfer rules
  one command is tracked at a time
  load words are expected to match bank_word, which the bank preset uses
  beat counts come from the input file through exp_beats
*/
`timescale 1ns/1ps
`default_nettype none

module vec_lsu_checker #(
    parameter int NUM_BANKS  = lsu_geom_pkg::NUM_BANKS,
    parameter int BANK_WIDTH = lsu_geom_pkg::BANK_WIDTH,
    parameter int ADDR_WIDTH = lsu_geom_pkg::ADDR_WIDTH,
    parameter int MAX_BEATS  = lsu_geom_pkg::MAX_BEATS
) (
    input  wire                                        clk,
    input  wire                                        nrst,
    input  wire                                        start,
    input  wire  [3:0]                                 op,
    input  wire  [ADDR_WIDTH-1:0]                      base_addr,
    input  wire  [NUM_BANKS*BANK_WIDTH*MAX_BEATS-1:0]  store_data,
    input  wire                                        busy,
    input  wire                                        done,
    input  wire  [NUM_BANKS*BANK_WIDTH*MAX_BEATS-1:0]  load_data,
    input  wire  [NUM_BANKS-1:0][ADDR_WIDTH-1:0]       bank_addr,
    input  wire  [NUM_BANKS-1:0][BANK_WIDTH-1:0]       bank_wdata,
    input  wire                                        bank_we,
    input  wire  [8*16-1:0]                            test_name,
    input  wire  [31:0]                                exp_beats,
    output int                                         errors,
    output int                                         checks
);

    localparam int VEC_WORDS = NUM_BANKS * MAX_BEATS;
    localparam int RL        = lsu_geom_pkg::READ_LATENCY;

    logic                             active;
    logic                             is_st;
    logic                             after_reset;
    int                               cyc;
    int                               n_beats;
    int                               writes;
    int                               done_cyc;
    logic [ADDR_WIDTH-1:0]            base_q;
    logic [VEC_WORDS*BANK_WIDTH-1:0]  sdata_q;
    logic [8*16-1:0]                  name_q;

    initial begin
        errors      = 0;
        checks      = 0;
        active      = 1'b0;
        after_reset = 1'b0;
    end

    // both address halves and the bank index show up in the word
    function automatic logic [BANK_WIDTH-1:0] bank_word(input logic [ADDR_WIDTH-1:0] a,
                                                        input int i);
        return BANK_WIDTH'({~a, a}) ^ (BANK_WIDTH'(i) << (BANK_WIDTH - 4));
    endfunction

    function automatic logic kept_op(input logic [3:0] code);
        return (code >= 4'd1 && code <= 4'd3) || (code >= 4'd7 && code <= 4'd9);
    endfunction

    task automatic compare(input logic [8*16-1:0] name, input string what,
                           input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED %0s %0s: expected %0h, actual %0h", name, what, exp, act);
        end
    endtask

    task automatic take_command();
        name_q   = test_name;
        base_q   = base_addr;
        sdata_q  = store_data;
        is_st    = (op >= 4'd7);
        n_beats  = exp_beats;
        writes   = 0;
        cyc      = 1;
        done_cyc = is_st ? n_beats + 2 : n_beats + 2 + RL;
        if (n_beats == 0) begin
            errors++;
            $display("%0s: the input file gives no beats for a kept opcode", test_name);
        end else begin
            active = 1'b1;
        end
    endtask

    task automatic check_cycle();
        int                    k;
        int                    w;
        logic [ADDR_WIDTH-1:0] a;
        logic [BANK_WIDTH-1:0] exp_word;
        logic                  beat_on;
        beat_on = is_st && cyc >= 2 && cyc <= n_beats + 1;
        compare(name_q, $sformatf("busy in cycle %0d", cyc), 1, busy);
        compare(name_q, $sformatf("done in cycle %0d", cyc), cyc == done_cyc, done);
        compare(name_q, $sformatf("bank_we in cycle %0d", cyc), beat_on, bank_we);
        if (bank_we) begin
            writes++;
        end
        if (beat_on) begin
            k = cyc - 2;
            for (int i = 0; i < NUM_BANKS; i++) begin
                w = k * NUM_BANKS + i;
                a = base_q + ADDR_WIDTH'(w);
                compare(name_q, $sformatf("bank_addr[%0d] beat %0d", i, k), a, bank_addr[i]);
                compare(name_q, $sformatf("bank_wdata[%0d] beat %0d", i, k),
                        sdata_q[w*BANK_WIDTH +: BANK_WIDTH], bank_wdata[i]);
            end
        end
        if (cyc == done_cyc) begin
            if (is_st) begin
                compare(name_q, "write cycles", n_beats, writes);
            end else begin
                for (w = 0; w < VEC_WORDS; w++) begin
                    a        = base_q + ADDR_WIDTH'(w);
                    exp_word = (w / NUM_BANKS < n_beats) ? bank_word(a, w % NUM_BANKS) : '0;
                    compare(name_q, $sformatf("load_data word %0d", w), exp_word,
                            load_data[w*BANK_WIDTH +: BANK_WIDTH]);
                end
            end
            active = 1'b0;
        end
        cyc++;
    endtask

    always @(posedge clk) begin
        if (!nrst) begin
            active      = 1'b0;
            after_reset = 1'b1;
        end else begin
            if (after_reset) begin
                after_reset = 1'b0;
                for (int w = 0; w < VEC_WORDS; w++) begin
                    compare("reset", $sformatf("load_data word %0d", w), 0,
                            load_data[w*BANK_WIDTH +: BANK_WIDTH]);
                end
            end
            if (active) begin
                check_cycle();
            end else begin
                compare(test_name, "busy while idle", 0, busy);
                compare(test_name, "done while idle", 0, done);
                compare(test_name, "bank_we while idle", 0, bank_we);
                if (start && !busy && kept_op(op)) begin
                    take_command();
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/vec_lsu.sv */
/*
  unit-stride vector load/store unit over word-interleaved banks
  one command in flight, starts while busy are dropped
  bank read data must follow the address by READ_LATENCY cycles
*/
`timescale 1ns/1ps
`default_nettype none

module vec_lsu #(
    parameter int NUM_BANKS  = lsu_geom_pkg::NUM_BANKS,
    parameter int BANK_WIDTH = lsu_geom_pkg::BANK_WIDTH,
    parameter int ADDR_WIDTH = lsu_geom_pkg::ADDR_WIDTH,
    parameter int MAX_BEATS  = lsu_geom_pkg::MAX_BEATS
) (
    input  wire                                        clk,
    input  wire                                        nrst,
    input  wire                                        start,
    input  lsu_instr_pkg::lsu_op_t                     op,
    input  lsu_instr_pkg::lmul_t                       lmul,
    input  wire  [ADDR_WIDTH-1:0]                      base_addr,
    input  wire  [NUM_BANKS*BANK_WIDTH*MAX_BEATS-1:0]  store_data,
    output logic                                       busy,
    output logic                                       done,
    output logic [NUM_BANKS*BANK_WIDTH*MAX_BEATS-1:0]  load_data,
    output logic [NUM_BANKS-1:0][ADDR_WIDTH-1:0]       bank_addr,
    output logic [NUM_BANKS-1:0][BANK_WIDTH-1:0]       bank_wdata,
    output logic                                       bank_we,
    input  wire  [NUM_BANKS-1:0][BANK_WIDTH-1:0]       bank_rdata
);

    logic                      accept;
    logic                      is_store;
    lsu_instr_pkg::beat_cnt_t  num_beats;
    logic [ADDR_WIDTH-1:0]     base;
    logic                      beat_adv;
    logic                      rd_beat;

    vec_cmd_decode #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .MAX_BEATS  (MAX_BEATS)
    ) u_decode (
        .clk       (clk),
        .nrst      (nrst),
        .start     (start),
        .op        (op),
        .lmul      (lmul),
        .base_addr (base_addr),
        .busy      (busy),
        .accept    (accept),
        .is_store  (is_store),
        .num_beats (num_beats),
        .base      (base)
    );

    vec_beat_sequencer #(
        .NUM_BANKS  (NUM_BANKS),
        .ADDR_WIDTH (ADDR_WIDTH),
        .MAX_BEATS  (MAX_BEATS)
    ) u_seq (
        .clk       (clk),
        .nrst      (nrst),
        .accept    (accept),
        .is_store  (is_store),
        .num_beats (num_beats),
        .base      (base),
        .busy      (busy),
        .beat_adv  (beat_adv),
        .rd_beat   (rd_beat),
        .bank_addr (bank_addr),
        .bank_we   (bank_we),
        .done      (done)
    );

    vec_store_slicer #(
        .NUM_BANKS  (NUM_BANKS),
        .BANK_WIDTH (BANK_WIDTH),
        .MAX_BEATS  (MAX_BEATS)
    ) u_store (
        .clk        (clk),
        .nrst       (nrst),
        .accept     (accept),
        .store_data (store_data),
        .beat_adv   (beat_adv),
        .bank_wdata (bank_wdata)
    );

    vec_load_packer #(
        .NUM_BANKS  (NUM_BANKS),
        .BANK_WIDTH (BANK_WIDTH),
        .MAX_BEATS  (MAX_BEATS)
    ) u_load (
        .clk        (clk),
        .nrst       (nrst),
        .accept     (accept),
        .rd_beat    (rd_beat),
        .bank_rdata (bank_rdata),
        .load_data  (load_data)
    );

endmodule

`default_nettype wire

/* verilog/vec_load_packer.sv */
/*
  load side: read data is taken READ_LATENCY cycles after each
  load beat and packed into the vector, beat 0 at the low end
  words above the register group stay zero
  load_data holds until the next accept clears it
*/
`timescale 1ns/1ps
`default_nettype none

module vec_load_packer #(
    parameter int NUM_BANKS  = 4,
    parameter int BANK_WIDTH = 32,
    parameter int MAX_BEATS  = 4
) (
    input  wire                                        clk,
    input  wire                                        nrst,
    input  wire                                        accept,
    input  wire                                        rd_beat,
    input  wire  [NUM_BANKS-1:0][BANK_WIDTH-1:0]       bank_rdata,
    output logic [NUM_BANKS*BANK_WIDTH*MAX_BEATS-1:0]  load_data
);

    localparam int BEAT_BITS = NUM_BANKS * BANK_WIDTH;
    localparam int IDX_W     = (MAX_BEATS > 1) ? $clog2(MAX_BEATS) : 1;
    localparam int RL        = lsu_geom_pkg::READ_LATENCY;

    logic [RL-1:0]    rd_pipe;
    logic [IDX_W-1:0] beat_idx;
    logic             capture;

    // rd_beat aligned with the bank read data
    assign capture = rd_pipe[RL-1];

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            rd_pipe   <= '0;
            beat_idx  <= '0;
            load_data <= '0;
        end else begin
            rd_pipe <= (rd_pipe << 1) | RL'(rd_beat);
            if (accept) begin
                load_data <= '0;
                beat_idx  <= '0;
            end else if (capture) begin
                load_data[beat_idx*BEAT_BITS +: BEAT_BITS] <= bank_rdata;
                beat_idx <= beat_idx + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/vec_store_slicer.sv */
/*
  store side: the vector is taken from store_data in the start
  cycle and committed on accept, then one beat per active cycle
  goes out lowest beat first
  bank_wdata is zero while no command is loaded
*/
`timescale 1ns/1ps
`default_nettype none

module vec_store_slicer #(
    parameter int NUM_BANKS  = 4,
    parameter int BANK_WIDTH = 32,
    parameter int MAX_BEATS  = 4
) (
    input  wire                                      clk,
    input  wire                                      nrst,
    input  wire                                      accept,
    input  wire  [NUM_BANKS*BANK_WIDTH*MAX_BEATS-1:0] store_data,
    input  wire                                      beat_adv,
    output logic [NUM_BANKS-1:0][BANK_WIDTH-1:0]     bank_wdata
);

    localparam int BEAT_BITS = NUM_BANKS * BANK_WIDTH;
    localparam int VEC_BITS  = BEAT_BITS * MAX_BEATS;

    logic [VEC_BITS-1:0] vec_q;
    logic                armed;
    logic                adv_q;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            armed <= 1'b0;
            adv_q <= 1'b0;
        end else begin
            adv_q <= beat_adv;
            if (accept) begin
                armed <= 1'b1;
            end else if (adv_q && !beat_adv) begin
                armed <= 1'b0;
            end
        end
    end

    // idle cycles follow store_data, so the start cycle value is kept
    always_ff @(posedge clk) begin
        if (beat_adv) begin
            vec_q <= vec_q >> BEAT_BITS;
        end else if (!armed && !accept) begin
            vec_q <= store_data;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            bank_wdata[i] = armed ? vec_q[i*BANK_WIDTH +: BANK_WIDTH] : '0;
        end
    end

endmodule

`default_nettype wire

/* verilog/vec_beat_sequencer.sv */
/*
  beat engine: one beat per cycle across all banks, starting
  the cycle after accept
  loads get a tail of READ_LATENCY cycles before done
  bank_addr reads zero whenever no beat is active
*/
`timescale 1ns/1ps
`default_nettype none

module vec_beat_sequencer #(
    parameter int NUM_BANKS  = 4,
    parameter int ADDR_WIDTH = 16,
    parameter int MAX_BEATS  = 4
) (
    input  wire                                      clk,
    input  wire                                      nrst,
    input  wire                                      accept,
    input  wire                                      is_store,
    input  lsu_instr_pkg::beat_cnt_t                 num_beats,
    input  wire  [ADDR_WIDTH-1:0]                    base,
    output logic                                     busy,
    output logic                                     beat_adv,
    output logic                                     rd_beat,
    output logic [NUM_BANKS-1:0][ADDR_WIDTH-1:0]     bank_addr,
    output logic                                     bank_we,
    output logic                                     done
);

    localparam int IDX_W = $clog2(MAX_BEATS) + 1;
    localparam int LAT_W = $clog2(lsu_geom_pkg::READ_LATENCY + 1);

    logic                      active;
    logic                      store_q;
    logic                      busy_q;
    lsu_instr_pkg::beat_cnt_t  num_q;
    logic [IDX_W-1:0]          beat_idx;
    logic [LAT_W-1:0]          tail;
    logic [ADDR_WIDTH-1:0]     run_addr;
    logic                      last_beat;

    assign last_beat = active && ((beat_idx + 1'b1) == IDX_W'(num_q));

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            active   <= 1'b0;
            store_q  <= 1'b0;
            busy_q   <= 1'b0;
            num_q    <= lsu_instr_pkg::beat_cnt_t'(1);
            beat_idx <= '0;
            tail     <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (accept) begin
                active   <= 1'b1;
                store_q  <= is_store;
                busy_q   <= 1'b1;
                num_q    <= num_beats;
                beat_idx <= '0;
                tail     <= '0;
            end else begin
                if (active) begin
                    beat_idx <= beat_idx + 1'b1;
                end
                if (last_beat) begin
                    active <= 1'b0;
                    if (store_q) begin
                        done <= 1'b1;
                    end else begin
                        tail <= LAT_W'(lsu_geom_pkg::READ_LATENCY);
                    end
                end
                // load tail, waiting for the last read data
                if (tail != '0) begin
                    tail <= tail - 1'b1;
                    if (tail == LAT_W'(1)) begin
                        done <= 1'b1;
                    end
                end
                if (done) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            run_addr <= base;
        end else if (active) begin
            run_addr <= run_addr + ADDR_WIDTH'(NUM_BANKS);
        end
    end

    // accept already counts as busy so a start in that cycle is dropped
    assign busy     = accept | busy_q;
    assign beat_adv = active;
    assign rd_beat  = active & ~store_q;
    assign bank_we  = active & store_q;

    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            bank_addr[i] = active ? run_addr + ADDR_WIDTH'(i) : '0;
        end
    end

endmodule

`default_nettype wire

/* verilog/vec_cmd_decode.sv */
/*
  command intake: a start is taken only while idle and only
  for a unit-stride opcode, anything else is dropped silently
  accept pulses one cycle after the start
  beat count is clipped to MAX_BEATS
*/
`timescale 1ns/1ps
`default_nettype none

module vec_cmd_decode #(
    parameter int ADDR_WIDTH = 16,
    parameter int MAX_BEATS  = 4
) (
    input  wire                       clk,
    input  wire                       nrst,
    input  wire                       start,
    input  lsu_instr_pkg::lsu_op_t    op,
    input  lsu_instr_pkg::lmul_t      lmul,
    input  wire  [ADDR_WIDTH-1:0]     base_addr,
    input  wire                       busy,
    output logic                      accept,
    output logic                      is_store,
    output lsu_instr_pkg::beat_cnt_t  num_beats,
    output logic [ADDR_WIDTH-1:0]     base
);

    logic                      take;
    lsu_instr_pkg::beat_cnt_t  group_beats;

    assign take        = start && !busy && lsu_instr_pkg::is_kept_op(op);
    assign group_beats = lsu_instr_pkg::lmul_beats(lmul);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            accept    <= 1'b0;
            is_store  <= 1'b0;
            num_beats <= lsu_instr_pkg::beat_cnt_t'(1);
            base      <= '0;
        end else begin
            accept <= take;
            // fields hold until the next accepted command
            if (take) begin
                is_store <= lsu_instr_pkg::is_store_op(op);
                if (group_beats > MAX_BEATS) begin
                    num_beats <= lsu_instr_pkg::beat_cnt_t'(MAX_BEATS);
                end else begin
                    num_beats <= group_beats;
                end
                base <= base_addr;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/lsu_instr_pkg.sv */
/*
  opcode and register-group encodings, unit-stride only
  element width does not change the bits moved, so the
  opcode only gives the direction
*/
`default_nettype none

package lsu_instr_pkg;

    typedef enum logic [3:0] {
        vle8  = 4'd1,
        vle16 = 4'd2,
        vle32 = 4'd3,
        vse8  = 4'd7,
        vse16 = 4'd8,
        vse32 = 4'd9
    } lsu_op_t;

    // unlisted codes behave as m1
    typedef enum logic [2:0] {
        m1 = 3'd0,
        m2 = 3'd1,
        m4 = 3'd2
    } lmul_t;

    typedef logic [2:0] beat_cnt_t;

    function automatic logic is_kept_op(lsu_op_t op);
        return op inside {vle8, vle16, vle32, vse8, vse16, vse32};
    endfunction

    function automatic logic is_store_op(lsu_op_t op);
        return op inside {vse8, vse16, vse32};
    endfunction

    function automatic beat_cnt_t lmul_beats(lmul_t lmul);
        case (lmul)
            m2:      return 3'd2;
            m4:      return 3'd4;
            default: return 3'd1;
        endcase
    endfunction

endpackage

`default_nettype wire

/* verilog/lsu_geom_pkg.sv */
/*
  memory and vector geometry of the load/store unit
  banks are word-interleaved, one beat spans all banks
  READ_LATENCY must be at least 1
*/
`default_nettype none

package lsu_geom_pkg;

    localparam int NUM_BANKS    = 4;
    localparam int BANK_WIDTH   = 32;
    // bank word address, not byte address
    localparam int ADDR_WIDTH   = 16;
    localparam int MAX_BEATS    = 4;
    // one register is one beat
    localparam int VREG_BITS    = NUM_BANKS * BANK_WIDTH;
    // cycles from bank address to read data
    localparam int READ_LATENCY = 1;

endpackage

`default_nettype wire
